/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --timescale 1ns/1ns
LINTFLAGS = --lint-only -Wall --timing --timescale 1ns/1ns
TOP       = tb_zmem
FILELIST  = sources.f
LOG       = sim.log
PASS_MSG  = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

/* dram_sequencer.sv */
`timescale 1ns/1ns

module dram_sequencer import zmem_pkg::*;
(
	input  logic        fclk,
	input  logic        rst_n,
	output dram_phase_t phase,
	input  logic        req,
	input  dram_req_t   req_data,
	output logic        next,
	output logic        strobe,
	output word_t       rddata,
	output logic [1:0]  store_we,
	output store_addr_t store_addr,
	output word_t       store_wdata,
	input  word_t       store_rdata
);

	dram_phase_t  ph;
	refresh_cnt_t round_cnt;
	logic         accept;

	// accepted request and its pipeline
	dram_req_t acc;
	logic      wr_go;
	logic      rd_s1;
	logic      rd_s2;

	assign phase  = ph;
	assign accept = (ph == c3) && req && next;

	// phase rotation and round count,
	// round_cnt steps on each c3
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ph        <= c0;
			round_cnt <= '0;
			next      <= 1'b0;
		end
		else
		begin
			ph <= dram_phase_t'(ph + 2'd1);
			if (ph == c3)
			begin
				if (round_cnt == refresh_cnt_t'(REFRESH_PERIOD - 1))
					round_cnt <= '0;
				else
					round_cnt <= round_cnt + 1'b1;
			end
			// block the c3 before the refresh round
			next <= !((ph == c2) && (round_cnt == refresh_cnt_t'(REFRESH_PERIOD - 1)));
		end
	end

	// request latch, held until the next acceptance
	always_ff @(posedge fclk)
	begin
		if (accept)
			acc <= req_data;
	end

	// write one cycle after acceptance,
	// read strobed three cycles after
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_go  <= 1'b0;
			rd_s1  <= 1'b0;
			rd_s2  <= 1'b0;
			strobe <= 1'b0;
		end
		else
		begin
			wr_go  <= accept && !req_data.rnw;
			rd_s1  <= accept && req_data.rnw;
			rd_s2  <= rd_s1;
			strobe <= rd_s2;
		end
	end

	// store output is valid in rd_s2, hold it for the strobe
	always_ff @(posedge fclk)
	begin
		if (rd_s2)
			rddata <= store_rdata;
	end

	// upper page bits fall off here
	assign store_addr  = acc.addr[STORE_ADDR_BITS-1:0];
	// byte on both lanes, enable picks one
	assign store_wdata = {acc.wrdata, acc.wrdata};
	assign store_we    = wr_go ? (acc.wrbsel ? 2'b10 : 2'b01) : 2'b00;

endmodule

/* mem_manager.sv */
`timescale 1ns/1ns

module mem_manager import zmem_pkg::*;
(
	input  logic            fclk,
	input  logic            rst_n,
	input  logic            zpos,
	input  logic            zneg,
	input  dram_phase_t     phase,
	input  zaddr_t          za,
	input  byte_t           zd_in,
	input  logic            m1_n,
	input  logic            rfsh_n,
	input  logic            mreq_n,
	input  logic            iorq_n,
	input  logic            rd_n,
	input  logic            wr_n,
	input  turbo_t          turbo,
	input  page_t [3:0]     win_page,
	input  logic  [3:0]     win_romnram,
	input  logic            romrw_en,
	output byte_t           zd_out,
	output logic            zd_ena,
	output logic            romoe_n,
	output logic            romwe_n,
	output logic            csrom,
	output logic  [4:0]     rompg,
	output logic            req,
	output dram_req_t       req_data,
	input  logic            next,
	input  logic            strobe,
	input  word_t           rddata,
	output logic            cpu_stall
);

	// window decode
	logic [1:0] win;
	page_t      page;
	logic       romnram;
	dram_addr_t word_addr;

	// bus cycle kinds
	logic opfetch;
	logic memrd;
	logic memwr;
	logic r_mreq_n;
	logic dram_beg;

	// read word and cache tag
	word_t      rd_buf;
	dram_addr_t cached_addr;
	logic       cached_valid;
	logic       cache_hit;

	// 14 MHz stall parts
	logic stall14_ini;
	logic stall14_cyc;
	logic stall14_cycrd;
	logic stall14_cycwr;
	logic stall14_fin;
	logic pending_req;
	logic rnw_r;

	// 3.5/7 MHz request edge detect
	logic ramreq;
	logic ramrd;
	logic ramwr;
	logic ramrd_reg;
	logic ramwr_reg;
	logic req_357;

	// io cycle start
	logic io;
	logic io_r;

	assign win       = za[15:14];
	assign page      = win_page[win];
	assign romnram   = win_romnram[win];
	assign word_addr = {page, za[13:1]};

	// rom chip controls straight from the pins
	assign rompg   = page[4:0];
	assign csrom   = romnram;
	assign romoe_n = rd_n | mreq_n;
	assign romwe_n = wr_n | mreq_n | ~romrw_en;

	// drive the cpu bus on ram reads only
	assign zd_ena = ~mreq_n & ~rd_n & ~romnram;

	assign opfetch = ~mreq_n & ~m1_n;
	assign memrd   = ~mreq_n & ~rd_n;
	assign memwr   = ~mreq_n & rd_n & rfsh_n;

	assign cache_hit = cached_valid && (cached_addr == word_addr);

	// mreq as seen on the previous falling edge
	// refresh counts as idle
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			r_mreq_n <= 1'b1;
		else if (zneg)
			r_mreq_n <= mreq_n | ~rfsh_n;
	end

	// first falling edge of a ram cycle that needs dram
	assign dram_beg = (!cache_hit || memwr) && zneg && r_mreq_n &&
		!romnram && !mreq_n && rfsh_n;

	// 14 MHz waits by phase at dram_beg
	// fetch c3 +3 .. c0 +6, read c3 +2 .. c0 +5
	// writes wait only on a refresh slot
	assign stall14_ini = dram_beg && (!next || opfetch || memrd);
	assign stall14_cyc = memwr ? (!next || stall14_cycwr) : stall14_cycrd;

	// reads hold until accepted at c3
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			stall14_cycrd <= 1'b0;
		else if (next && phase == c3)
			stall14_cycrd <= 1'b0;
		else if (dram_beg && (phase != c3 || !next) && (opfetch || memrd))
			stall14_cycrd <= 1'b1;
	end

	// a write pushed back by refresh holds the cpu until taken
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			stall14_cycwr <= 1'b0;
		else if (next && phase == c3)
			stall14_cycwr <= 1'b0;
		else if (!next && phase == c3 && (pending_req || dram_beg) && memwr)
			stall14_cycwr <= 1'b1;
	end

	// wait after acceptance for the data to come back
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			stall14_fin <= 1'b0;
		else if (stall14_fin && (opfetch ? (phase == c2) : (memrd && phase == c1)))
			stall14_fin <= 1'b0;
		else if (next && phase == c3 && req && (opfetch || memrd))
			stall14_fin <= 1'b1;
	end

	// request stays up until the c3 that takes it
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			pending_req <= 1'b0;
		else if (next && phase == c3)
			pending_req <= 1'b0;
		else if (dram_beg)
			pending_req <= 1'b1;
	end

	// direction kept for the held request
	always_ff @(posedge fclk)
	begin
		if (dram_beg)
			rnw_r <= !memwr;
	end

	// slow modes make one request per ram read or write
	// edge taken on c3 unless stalled
	assign ramreq = ~mreq_n & ~romnram & rfsh_n;
	assign ramrd  = ramreq & ~rd_n;
	assign ramwr  = ramreq & ~wr_n;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ramrd_reg <= 1'b0;
			ramwr_reg <= 1'b0;
		end
		else if (phase == c3 && !cpu_stall)
		begin
			ramrd_reg <= ramrd;
			ramwr_reg <= ramwr;
		end
	end

	assign req_357 = (ramrd & ~ramrd_reg) | (ramwr & ~ramwr_reg);

	assign cpu_stall = turbo[1] ? (stall14_ini | stall14_cyc | stall14_fin) :
		(req_357 & ~next);
	assign req = turbo[1] ? (pending_req | dram_beg) : req_357;

	always_comb
	begin
		req_data.rnw    = turbo[1] ? (dram_beg ? !memwr : rnw_r) : ramrd;
		req_data.addr   = word_addr;
		req_data.wrdata = zd_in;
		req_data.wrbsel = za[0];
	end

	// word from the sequencer
	always_ff @(posedge fclk)
	begin
		if (strobe)
			rd_buf <= rddata;
	end

	// byte chosen by za[0]
	assign zd_out = za[0] ? rd_buf[15:8] : rd_buf[7:0];

	// io cycle start seen on rising zclk
	assign io = ~iorq_n;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			io_r <= 1'b0;
		else if (zpos)
			io_r <= io;
	end

	// drop the cached word on rom access, write or io start
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			cached_valid <= 1'b0;
		else if ((zneg && r_mreq_n && !mreq_n && rfsh_n && romnram) ||
			(zneg && r_mreq_n && memwr) ||
			(io && !io_r && zpos))
			cached_valid <= 1'b0;
		else if (strobe)
			cached_valid <= 1'b1;
	end

	// tag is the full dram address so remapping a window cannot hit
	always_ff @(posedge fclk)
	begin
		if (strobe)
			cached_addr <= word_addr;
	end

endmodule

/* sources.f */
zmem_pkg.sv
zclock_gen.sv
mem_manager.sv
dram_sequencer.sv
word_store.sv
zmem_top.sv
tb_zmem.sv

/* tb_zmem.sv */
`timescale 1ns/1ns

module tb_zmem import zmem_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 5;
	localparam int DRIVE_DLY = 10;
	localparam int SAMPLE_DLY = 5;

	// bus cycle kinds
	localparam int CYC_FETCH = 0;
	localparam int CYC_READ = 1;
	localparam int CYC_WRITE = 2;

	// test lengths in bus cycles
	localparam int N_RANDOM = 240;
	localparam int N_FILL = 32;
	localparam int N_FETCH_ROUNDS = 10;
	localparam int MISC_CYCLES = 40;
	localparam int TOTAL_CYCLES = N_RANDOM + N_FILL + N_FILL * N_FETCH_ROUNDS + MISC_CYCLES;

	// slowest cycle is four T states at 3.5 MHz, plus room for refresh waits
	localparam int SLOW_CYCLE_FCLK = 4 * 2 * 8;
	localparam int REFRESH_MARGIN_FCLK = 16;
	localparam int WATCHDOG_NS =
		(RESET_CYCLES + TOTAL_CYCLES * (SLOW_CYCLE_FCLK + REFRESH_MARGIN_FCLK)) * CLK_PERIOD;

	logic        fclk;
	logic        rst_n;
	zaddr_t      za;
	byte_t       zd_in;
	logic        m1_n;
	logic        rfsh_n;
	logic        mreq_n;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	turbo_t      turbo;
	page_t [3:0] win_page;
	logic  [3:0] win_romnram;
	logic        romrw_en;
	byte_t       zd_out;
	logic        zd_ena;
	logic        zclk;
	logic  [4:0] rompg;
	logic        romoe_n;
	logic        romwe_n;
	logic        csrom;

	// memory model, indexed by page[1:0] and offset
	byte_t model [0:65535];
	logic  written [0:65535];

	logic [15:0] lfsr_state;

	zmem_top DUT
	(
		.fclk        (fclk),
		.rst_n       (rst_n),
		.za          (za),
		.zd_in       (zd_in),
		.m1_n        (m1_n),
		.rfsh_n      (rfsh_n),
		.mreq_n      (mreq_n),
		.iorq_n      (iorq_n),
		.rd_n        (rd_n),
		.wr_n        (wr_n),
		.turbo       (turbo),
		.win_page    (win_page),
		.win_romnram (win_romnram),
		.romrw_en    (romrw_en),
		.zd_out      (zd_out),
		.zd_ena      (zd_ena),
		.zclk        (zclk),
		.rompg       (rompg),
		.romoe_n     (romoe_n),
		.romwe_n     (romwe_n),
		.csrom       (csrom)
	);

	initial
	begin
		fclk = 1'b0;
		forever
			#(CLK_PERIOD / 2) fclk = ~fclk;
	end

	// watchdog sized from the total bus cycle count
	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: bus cycles still running at %0t", $time);
		stop_with_failure();
	end

	task automatic stop_with_failure();
		$display("Finished with errors");
		$fatal(1, "run stopped");
	endtask

	// 16 bit fibonacci lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one lfsr step per bit taken
	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
	endtask

	function automatic logic [15:0] model_index(input page_t pg, input zaddr_t a);
		return {pg[1:0], a[13:0]};
	endfunction

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s got %02h expected %02h", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_rom(input logic [4:0] got_pg, input logic got_cs,
		input logic [4:0] exp_pg, input logic exp_cs, input string what);
		if (got_cs !== exp_cs || (exp_cs && got_pg !== exp_pg))
		begin
			$display("CHECK FAILED at %0t: %s got page %0d cs %b expected page %0d cs %b",
				$time, what, got_pg, got_cs, exp_pg, exp_cs);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	// rom select and strobes while the bus strobes are low
	task automatic check_strobes(input logic is_write);
		logic [1:0] w;
		w = za[15:14];
		check_rom(rompg, csrom, win_page[w][4:0], win_romnram[w], "rom select");
		check_bit(romoe_n, is_write, "romoe_n");
		check_bit(romwe_n, !(is_write && romrw_en), "romwe_n");
		check_bit(zd_ena, !is_write && !win_romnram[w], "zd_ena");
	endtask

	// one z80 memory cycle, paced by zclk edges only
	task automatic bus_cycle(input int kind, input zaddr_t a, input byte_t d,
		output byte_t got);
		logic is_fetch;
		logic is_write;
		is_fetch = (kind == CYC_FETCH);
		is_write = (kind == CYC_WRITE);
		got = '0;
		// T1 rise, address out
		@(posedge zclk);
		#DRIVE_DLY;
		za = a;
		zd_in = d;
		m1_n = !is_fetch;
		// T1 fall
		@(negedge zclk);
		#DRIVE_DLY;
		mreq_n = 1'b0;
		rd_n = is_write;
		// T2
		@(posedge zclk);
		@(negedge zclk);
		#DRIVE_DLY;
		wr_n = !is_write;
		// T3 rise
		@(posedge zclk);
		#SAMPLE_DLY;
		if (is_fetch)
		begin
			got = zd_out;
			#(DRIVE_DLY - SAMPLE_DLY);
			mreq_n = 1'b1;
			rd_n = 1'b1;
			m1_n = 1'b1;
			rfsh_n = 1'b0;
			// refresh in T3 and T4
			@(negedge zclk);
			#DRIVE_DLY;
			mreq_n = 1'b0;
			@(posedge zclk);
			@(negedge zclk);
			#DRIVE_DLY;
			mreq_n = 1'b1;
			rfsh_n = 1'b1;
		end
		else
		begin
			check_strobes(is_write);
			// read data taken at T3 fall
			@(negedge zclk);
			#SAMPLE_DLY;
			got = zd_out;
			#(DRIVE_DLY - SAMPLE_DLY);
			mreq_n = 1'b1;
			rd_n = 1'b1;
			wr_n = 1'b1;
		end
	endtask

	// io read, T1 T2 TW T3
	task automatic io_cycle(input zaddr_t a);
		@(posedge zclk);
		#DRIVE_DLY;
		za = a;
		m1_n = 1'b1;
		@(posedge zclk);
		#DRIVE_DLY;
		iorq_n = 1'b0;
		rd_n = 1'b0;
		@(posedge zclk);
		@(posedge zclk);
		@(negedge zclk);
		#DRIVE_DLY;
		iorq_n = 1'b1;
		rd_n = 1'b1;
	endtask

	// ram cycle through the current window mapping, model updated or compared
	task automatic ram_access(input int kind, input zaddr_t a, input byte_t d);
		logic [15:0] idx;
		byte_t       got;
		idx = model_index(win_page[a[15:14]], a);
		bus_cycle(kind, a, d, got);
		if (kind == CYC_WRITE)
		begin
			model[idx] = d;
			written[idx] = 1'b1;
		end
		else
			check_byte(got, model[idx], "ram read");
	endtask

	task automatic random_rw();
		logic [15:0] r;
		logic [1:0]  w;
		zaddr_t      a;
		int          kind;
		for (int i = 0; i < N_RANDOM; i++)
		begin
			take_bits(2, r);
			turbo = r[1:0];
			take_bits(2, r);
			w = r[1:0];
			take_bits(2, r);
			win_page[w] = page_t'(r[1:0]);
			// small offset pool so reads land on written bytes
			take_bits(5, r);
			a = {w, 9'd0, r[4:0]};
			take_bits(2, r);
			kind = r[1] ? CYC_WRITE : (r[0] ? CYC_READ : CYC_FETCH);
			if (kind != CYC_WRITE && !written[model_index(win_page[w], a)])
				kind = CYC_WRITE;
			take_bits(8, r);
			ram_access(kind, a, r[7:0]);
		end
	endtask

	// same page seen through windows 1 and 2
	task automatic paging_test();
		logic [15:0] r;
		win_page[1] = page_t'(2);
		win_page[2] = page_t'(2);
		for (int i = 0; i < 8; i++)
		begin
			take_bits(2, r);
			turbo = r[1:0];
			take_bits(8, r);
			ram_access(CYC_WRITE, {2'b01, 14'(i + 64)}, r[7:0]);
			ram_access(CYC_READ, {2'b10, 14'(i + 64)}, 8'h00);
		end
	endtask

	task automatic cache_test();
		turbo = 2'b11;
		win_page[0] = page_t'(1);
		ram_access(CYC_WRITE, 16'h0100, 8'h5a);
		ram_access(CYC_WRITE, 16'h0101, 8'ha5);
		// repeated reads and both bytes of one word
		ram_access(CYC_READ, 16'h0100, 8'h00);
		ram_access(CYC_READ, 16'h0100, 8'h00);
		ram_access(CYC_READ, 16'h0101, 8'h00);
		// write in between must show up
		ram_access(CYC_WRITE, 16'h0101, 8'h3c);
		ram_access(CYC_READ, 16'h0101, 8'h00);
		ram_access(CYC_READ, 16'h0100, 8'h00);
		io_cycle(16'h00fe);
		ram_access(CYC_READ, 16'h0100, 8'h00);
		ram_access(CYC_READ, 16'h0101, 8'h00);
	endtask

	task automatic rom_test();
		byte_t got;
		turbo = 2'b10;
		win_page[0] = page_t'(3);
		win_romnram = 4'b0000;
		ram_access(CYC_WRITE, 16'h0200, 8'h77);
		// page 0x63 would alias onto ram page 3
		win_page[1] = page_t'(8'h63);
		win_romnram = 4'b0010;
		romrw_en = 1'b1;
		bus_cycle(CYC_WRITE, 16'h4200, 8'h11, got);
		romrw_en = 1'b0;
		bus_cycle(CYC_WRITE, 16'h4200, 8'h22, got);
		bus_cycle(CYC_READ, 16'h4200, 8'h00, got);
		turbo = 2'b00;
		romrw_en = 1'b1;
		bus_cycle(CYC_WRITE, 16'h4200, 8'h33, got);
		bus_cycle(CYC_READ, 16'h4201, 8'h00, got);
		romrw_en = 1'b0;
		win_romnram = 4'b0000;
		// ram behind the rom page is untouched
		ram_access(CYC_READ, 16'h0200, 8'h00);
	endtask

	// long fetch runs at 14 MHz cross several refresh slots
	task automatic fetch_test();
		logic [15:0] r;
		turbo = 2'b10;
		win_page[3] = page_t'(2);
		for (int i = 0; i < N_FILL; i++)
		begin
			take_bits(8, r);
			ram_access(CYC_WRITE, {2'b11, 14'(16'h1000 + i)}, r[7:0]);
		end
		for (int n = 0; n < N_FETCH_ROUNDS; n++)
			for (int i = 0; i < N_FILL; i++)
				ram_access(CYC_FETCH, {2'b11, 14'(16'h1000 + i)}, 8'h00);
	endtask

	initial
	begin
		rst_n = 1'b0;
		za = '0;
		zd_in = '0;
		m1_n = 1'b1;
		rfsh_n = 1'b1;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		turbo = 2'b10;
		win_page = '0;
		win_romnram = 4'b0000;
		romrw_en = 1'b0;
		lfsr_state = 16'd50;
		for (int i = 0; i < 65536; i++)
			written[i] = 1'b0;
		repeat (RESET_CYCLES) @(posedge fclk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		random_rw();
		paging_test();
		cache_test();
		rom_test();
		fetch_test();
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* word_store.sv */
`timescale 1ns/1ns

module word_store import zmem_pkg::*;
(
	input  logic        fclk,
	input  logic [1:0]  we,
	input  store_addr_t addr,
	input  word_t       wdata,
	output word_t       rdata
);

	// 32k words
	word_t mem [2**STORE_ADDR_BITS];

	// per-lane writes
	always_ff @(posedge fclk)
	begin
		if (we[0])
			mem[addr][7:0] <= wdata[7:0];
		if (we[1])
			mem[addr][15:8] <= wdata[15:8];
	end

	// registered read, old data on a same-cycle write
	always_ff @(posedge fclk)
	begin
		rdata <= mem[addr];
	end

endmodule

/* zclock_gen.sv */
`timescale 1ns/1ns

module zclock_gen import zmem_pkg::*;
(
	input  logic   fclk,
	input  logic   rst_n,
	input  turbo_t turbo,
	input  logic   stall,
	output logic   zclk,
	output logic   zpos,
	output logic   zneg
);

	// fclk cycles left in the current half period
	zclk_cnt_t half_cnt;
	zclk_cnt_t reload;

	// reload value, one less than the half period
	// since the strobe cycle itself counts
	always_comb
	begin
		if (turbo[1])
			reload = zclk_cnt_t'(ZCLK_HALF_14 - 1);
		else if (turbo[0])
			reload = zclk_cnt_t'(ZCLK_HALF_7 - 1);
		else
			reload = zclk_cnt_t'(ZCLK_HALF_35 - 1);
	end

	// strobes are registered a cycle ahead of the edge,
	// zclk toggles at the end of the strobe cycle
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			zclk     <= 1'b0;
			zpos     <= 1'b0;
			zneg     <= 1'b0;
			// first rising edge comes early
			half_cnt <= zclk_cnt_t'(1);
		end
		else
		begin
			zpos <= 1'b0;
			zneg <= 1'b0;
			if (zpos || zneg)
			begin
				// edge taken, start next half period
				zclk     <= ~zclk;
				half_cnt <= reload;
			end
			else if (!stall && half_cnt != '0)
			begin
				half_cnt <= half_cnt - 1'b1;
				// last count, announce the coming edge
				if (half_cnt == zclk_cnt_t'(1))
				begin
					zpos <= ~zclk;
					zneg <= zclk;
				end
			end
			// stall freezes the count, zclk holds its level
		end
	end

endmodule

/* zmem_pkg.sv */
package zmem_pkg;

	// cpu side data byte and address
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] zaddr_t;

	// dram data word, two byte lanes
	typedef logic [15:0] word_t;

	// 16k page number, one per window
	typedef logic [7:0]  page_t;

	// dram word address: page then za[13:1]
	typedef logic [20:0] dram_addr_t;

	// speed select
	// 00 is 3.5 MHz, 01 is 7 MHz, 1x is 14 MHz
	typedef logic [1:0]  turbo_t;

	// dram phases, one step per fclk
	typedef enum logic [1:0]
	{
		c0,
		c1,
		c2,
		c3
	} dram_phase_t;

	// one cpu word request to the sequencer
	typedef struct packed
	{
		logic       rnw;
		dram_addr_t addr;
		byte_t      wrdata;
		// high byte lane on write
		logic       wrbsel;
	} dram_req_t;

	// word address bits kept by the store
	// pages above 3 alias onto 0..3
	localparam int STORE_ADDR_BITS = 15;
	typedef logic [STORE_ADDR_BITS-1:0] store_addr_t;

	// full phase rounds between refresh slots
	localparam int REFRESH_PERIOD = 64;
	localparam int REFRESH_BITS = $clog2(REFRESH_PERIOD);
	typedef logic [REFRESH_BITS-1:0] refresh_cnt_t;

	// zclk half periods in fclk cycles
	localparam int ZCLK_HALF_14 = 2;
	localparam int ZCLK_HALF_7 = 4;
	localparam int ZCLK_HALF_35 = 8;

	// counter wide enough for the slowest half period
	localparam int ZCLK_CNT_BITS = $clog2(ZCLK_HALF_35);
	typedef logic [ZCLK_CNT_BITS-1:0] zclk_cnt_t;

endpackage

/* zmem_top.sv */
`timescale 1ns/1ns

module zmem_top import zmem_pkg::*;
(
	input  logic        fclk,
	input  logic        rst_n,
	input  zaddr_t      za,
	input  byte_t       zd_in,
	input  logic        m1_n,
	input  logic        rfsh_n,
	input  logic        mreq_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  turbo_t      turbo,
	input  page_t [3:0] win_page,
	input  logic  [3:0] win_romnram,
	input  logic        romrw_en,
	output byte_t       zd_out,
	output logic        zd_ena,
	output logic        zclk,
	output logic  [4:0] rompg,
	output logic        romoe_n,
	output logic        romwe_n,
	output logic        csrom
);

	// clock strobes and stall
	logic zpos;
	logic zneg;
	logic cpu_stall;

	// request handshake
	dram_phase_t phase;
	logic        req;
	dram_req_t   req_data;
	logic        next;
	logic        strobe;
	word_t       rddata;

	// store port
	logic [1:0]  store_we;
	store_addr_t store_addr;
	word_t       store_wdata;
	word_t       store_rdata;

	zclock_gen u_clock
	(
		.fclk  (fclk),
		.rst_n (rst_n),
		.turbo (turbo),
		.stall (cpu_stall),
		.zclk  (zclk),
		.zpos  (zpos),
		.zneg  (zneg)
	);

	mem_manager u_mem
	(
		.fclk        (fclk),
		.rst_n       (rst_n),
		.zpos        (zpos),
		.zneg        (zneg),
		.phase       (phase),
		.za          (za),
		.zd_in       (zd_in),
		.m1_n        (m1_n),
		.rfsh_n      (rfsh_n),
		.mreq_n      (mreq_n),
		.iorq_n      (iorq_n),
		.rd_n        (rd_n),
		.wr_n        (wr_n),
		.turbo       (turbo),
		.win_page    (win_page),
		.win_romnram (win_romnram),
		.romrw_en    (romrw_en),
		.zd_out      (zd_out),
		.zd_ena      (zd_ena),
		.romoe_n     (romoe_n),
		.romwe_n     (romwe_n),
		.csrom       (csrom),
		.rompg       (rompg),
		.req         (req),
		.req_data    (req_data),
		.next        (next),
		.strobe      (strobe),
		.rddata      (rddata),
		.cpu_stall   (cpu_stall)
	);

	dram_sequencer u_seq
	(
		.fclk        (fclk),
		.rst_n       (rst_n),
		.phase       (phase),
		.req         (req),
		.req_data    (req_data),
		.next        (next),
		.strobe      (strobe),
		.rddata      (rddata),
		.store_we    (store_we),
		.store_addr  (store_addr),
		.store_wdata (store_wdata),
		.store_rdata (store_rdata)
	);

	word_store u_store
	(
		.fclk  (fclk),
		.we    (store_we),
		.addr  (store_addr),
		.wdata (store_wdata),
		.rdata (store_rdata)
	);

endmodule
